// File: hdl/branch_unit.sv
`default_nettype none

module branch_unit (
    input  wire  [mips_id_pkg::word_w-1:0]  id_pc,
    input  wire  [mips_id_pkg::word_w-1:0]  id_inst,
    input  wire  mips_id_pkg::br_kind_e     br_kind,
    input  wire  [mips_id_pkg::word_w-1:0]  rs_value,
    input  wire  [mips_id_pkg::word_w-1:0]  rt_value,
    output logic                            br_taken,
    output logic [mips_id_pkg::word_w-1:0]  br_target
);

    logic [mips_id_pkg::word_w-1:0] pc_plus_4;
    logic [mips_id_pkg::word_w-1:0] br_offset;
    logic [mips_id_pkg::word_w-1:0] jump_target;
    logic                           rs_neg;
    logic                           rs_zero;

    // delay slot pc is the base for every pc-relative target
    assign pc_plus_4   = id_pc + 32'd4;
    assign br_offset   = {{14{id_inst[15]}}, id_inst[15:0], 2'b00};
    assign jump_target = {pc_plus_4[31:28], id_inst[25:0], 2'b00};

    assign rs_neg  = rs_value[mips_id_pkg::word_w-1];
    assign rs_zero = (rs_value == '0);

    always_comb begin
        br_taken  = 1'b0;
        br_target = pc_plus_4 + br_offset;
        case (br_kind)
            mips_id_pkg::br_beq: br_taken = (rs_value == rt_value);
            mips_id_pkg::br_bne: br_taken = (rs_value != rt_value);
            mips_id_pkg::br_bgez, mips_id_pkg::br_bgezal: br_taken = !rs_neg;
            mips_id_pkg::br_bltz, mips_id_pkg::br_bltzal: br_taken = rs_neg;
            mips_id_pkg::br_bgtz: br_taken = !rs_neg && !rs_zero;
            mips_id_pkg::br_blez: br_taken = rs_neg || rs_zero;
            mips_id_pkg::br_j, mips_id_pkg::br_jal: begin
                br_taken  = 1'b1;
                br_target = jump_target;
            end
            mips_id_pkg::br_jr, mips_id_pkg::br_jalr: begin
                br_taken  = 1'b1;
                br_target = rs_value;
            end
            default: br_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/if_id_latch.sv
`default_nettype none

module if_id_latch (
    input  wire                             clk,
    input  wire                             rst,
    input  wire  [mips_id_pkg::word_w-1:0]  if_pc,
    input  wire                             if_ce,
    input  wire  [mips_id_pkg::word_w-1:0]  inst_rdata,
    input  wire                             id_stall,
    input  wire                             ex_stall,
    output logic [mips_id_pkg::word_w-1:0]  id_pc,
    output logic [mips_id_pkg::word_w-1:0]  id_inst
);

    logic                             id_ce;
    logic                             buf_valid;
    logic [mips_id_pkg::word_w-1:0]   inst_buf;

    always_ff @(posedge clk) begin
        if (rst) begin
            id_pc     <= '0;
            id_ce     <= 1'b0;
            buf_valid <= 1'b0;
        end else if (id_stall && !ex_stall) begin
            // bubble into EX, ID holds nothing valid
            id_ce     <= 1'b0;
            buf_valid <= 1'b0;
        end else if (!id_stall) begin
            id_pc     <= if_pc;
            id_ce     <= if_ce;
            buf_valid <= 1'b0;
        end else if (!buf_valid) begin
            buf_valid <= 1'b1;
        end
    end

    // memory output moves on during a full stall, keep the first word
    always_ff @(posedge clk) begin
        if (id_stall && ex_stall && !buf_valid) begin
            inst_buf <= inst_rdata;
        end
    end

    // invalid slot reads as the all-zero word (sll r0)
    assign id_inst = !id_ce ? '0 : (buf_valid ? inst_buf : inst_rdata);

endmodule

`default_nettype wire

// File: hdl/inst_decoder.sv
`default_nettype none

module inst_decoder (
    input  wire  [mips_id_pkg::word_w-1:0]      id_inst,
    output mips_id_pkg::alu_op_e                alu_op,
    output mips_id_pkg::alu_src1_e              alu_src1,
    output mips_id_pkg::alu_src2_e              alu_src2,
    output mips_id_pkg::mem_op_e                mem_op,
    output logic                                rf_we,
    output logic [mips_id_pkg::reg_addr_w-1:0]  rf_waddr,
    output mips_id_pkg::br_kind_e               br_kind
);

    // REGIMM branch codes in the rt field
    localparam logic [mips_id_pkg::reg_addr_w-1:0] rt_bltz   = 5'h00;
    localparam logic [mips_id_pkg::reg_addr_w-1:0] rt_bgez   = 5'h01;
    localparam logic [mips_id_pkg::reg_addr_w-1:0] rt_bltzal = 5'h10;
    localparam logic [mips_id_pkg::reg_addr_w-1:0] rt_bgezal = 5'h11;

    mips_id_pkg::opcode_e                 opcode;
    mips_id_pkg::funct_e                  funct;
    mips_id_pkg::alu_op_e                 op_raw;
    logic [mips_id_pkg::reg_addr_w-1:0]   rt;
    logic [mips_id_pkg::reg_addr_w-1:0]   dst;
    logic                                 wr;
    logic                                 link;
    logic                                 is_load;

    assign opcode = mips_id_pkg::opcode_e'(id_inst[31:26]);
    assign funct  = mips_id_pkg::funct_e'(id_inst[5:0]);
    assign rt     = id_inst[20:16];

    always_comb begin
        case (opcode)
            mips_id_pkg::op_lb:  mem_op = mips_id_pkg::mem_lb;
            mips_id_pkg::op_lbu: mem_op = mips_id_pkg::mem_lbu;
            mips_id_pkg::op_lh:  mem_op = mips_id_pkg::mem_lh;
            mips_id_pkg::op_lhu: mem_op = mips_id_pkg::mem_lhu;
            mips_id_pkg::op_lw:  mem_op = mips_id_pkg::mem_lw;
            mips_id_pkg::op_sb:  mem_op = mips_id_pkg::mem_sb;
            mips_id_pkg::op_sh:  mem_op = mips_id_pkg::mem_sh;
            mips_id_pkg::op_sw:  mem_op = mips_id_pkg::mem_sw;
            default:             mem_op = mips_id_pkg::mem_none;
        endcase
    end

    assign is_load = (mem_op == mips_id_pkg::mem_lb) || (mem_op == mips_id_pkg::mem_lbu)
                  || (mem_op == mips_id_pkg::mem_lh) || (mem_op == mips_id_pkg::mem_lhu)
                  || (mem_op == mips_id_pkg::mem_lw);

    always_comb begin
        op_raw   = mips_id_pkg::alu_none;
        alu_src1 = mips_id_pkg::src1_rs;
        alu_src2 = mips_id_pkg::src2_none;
        br_kind  = mips_id_pkg::br_none;
        dst      = rt;
        wr       = 1'b0;
        link     = 1'b0;
        case (opcode)
            mips_id_pkg::op_special: begin
                wr       = 1'b1;
                dst      = id_inst[15:11];
                alu_src2 = mips_id_pkg::src2_rt;
                // shift amount comes from the sa field
                if (funct inside {mips_id_pkg::fn_sll, mips_id_pkg::fn_srl, mips_id_pkg::fn_sra})
                    alu_src1 = mips_id_pkg::src1_sa;
                case (funct)
                    mips_id_pkg::fn_add, mips_id_pkg::fn_addu: op_raw = mips_id_pkg::alu_add;
                    mips_id_pkg::fn_sub, mips_id_pkg::fn_subu: op_raw = mips_id_pkg::alu_sub;
                    mips_id_pkg::fn_slt:  op_raw = mips_id_pkg::alu_slt;
                    mips_id_pkg::fn_sltu: op_raw = mips_id_pkg::alu_sltu;
                    mips_id_pkg::fn_and:  op_raw = mips_id_pkg::alu_and;
                    mips_id_pkg::fn_or:   op_raw = mips_id_pkg::alu_or;
                    mips_id_pkg::fn_xor:  op_raw = mips_id_pkg::alu_xor;
                    mips_id_pkg::fn_nor:  op_raw = mips_id_pkg::alu_nor;
                    mips_id_pkg::fn_sll, mips_id_pkg::fn_sllv: op_raw = mips_id_pkg::alu_sll;
                    mips_id_pkg::fn_srl, mips_id_pkg::fn_srlv: op_raw = mips_id_pkg::alu_srl;
                    mips_id_pkg::fn_sra, mips_id_pkg::fn_srav: op_raw = mips_id_pkg::alu_sra;
                    mips_id_pkg::fn_jr: begin
                        wr = 1'b0;
                        if (id_inst[20:6] == '0)
                            br_kind = mips_id_pkg::br_jr;
                    end
                    mips_id_pkg::fn_jalr: begin
                        // links into rd
                        wr   = 1'b0;
                        link = (rt == '0) && (id_inst[10:6] == '0);
                        if (link)
                            br_kind = mips_id_pkg::br_jalr;
                    end
                    default: wr = 1'b0;
                endcase
            end
            mips_id_pkg::op_regimm: begin
                dst = mips_id_pkg::link_reg;
                case (rt)
                    rt_bltz:   br_kind = mips_id_pkg::br_bltz;
                    rt_bgez:   br_kind = mips_id_pkg::br_bgez;
                    rt_bltzal: br_kind = mips_id_pkg::br_bltzal;
                    rt_bgezal: br_kind = mips_id_pkg::br_bgezal;
                    default:   br_kind = mips_id_pkg::br_none;
                endcase
                link = (rt == rt_bltzal) || (rt == rt_bgezal);
            end
            mips_id_pkg::op_j: br_kind = mips_id_pkg::br_j;
            mips_id_pkg::op_jal: begin
                br_kind = mips_id_pkg::br_jal;
                dst     = mips_id_pkg::link_reg;
                link    = 1'b1;
            end
            mips_id_pkg::op_beq: br_kind = mips_id_pkg::br_beq;
            mips_id_pkg::op_bne: br_kind = mips_id_pkg::br_bne;
            mips_id_pkg::op_blez: if (rt == '0) br_kind = mips_id_pkg::br_blez;
            mips_id_pkg::op_bgtz: if (rt == '0) br_kind = mips_id_pkg::br_bgtz;
            mips_id_pkg::op_addi, mips_id_pkg::op_addiu: op_raw = mips_id_pkg::alu_add;
            mips_id_pkg::op_slti:  op_raw = mips_id_pkg::alu_slt;
            mips_id_pkg::op_sltiu: op_raw = mips_id_pkg::alu_sltu;
            mips_id_pkg::op_andi:  op_raw = mips_id_pkg::alu_and;
            mips_id_pkg::op_ori:   op_raw = mips_id_pkg::alu_or;
            mips_id_pkg::op_xori:  op_raw = mips_id_pkg::alu_xor;
            mips_id_pkg::op_lui:   op_raw = mips_id_pkg::alu_lui;
            default: op_raw = mips_id_pkg::alu_none;
        endcase
        // immediate ALU forms write rt, logic ops zero extend
        if (opcode inside {[mips_id_pkg::op_addi:mips_id_pkg::op_lui]}) begin
            wr       = 1'b1;
            alu_src2 = (opcode inside {[mips_id_pkg::op_andi:mips_id_pkg::op_xori]})
                     ? mips_id_pkg::src2_imm_zero : mips_id_pkg::src2_imm_sign;
        end
        // address is base plus offset
        if (mem_op != mips_id_pkg::mem_none) begin
            op_raw   = mips_id_pkg::alu_add;
            alu_src2 = mips_id_pkg::src2_imm_sign;
            wr       = is_load;
        end
        // return address is pc + 8, past the delay slot
        if (link) begin
            wr       = 1'b1;
            op_raw   = mips_id_pkg::alu_add;
            alu_src1 = mips_id_pkg::src1_pc;
            alu_src2 = mips_id_pkg::src2_eight;
        end
    end

    assign rf_we    = wr && (dst != '0);
    assign rf_waddr = wr ? dst : '0;
    // ALU idles when its result goes nowhere
    assign alu_op   = (rf_we || mem_op != mips_id_pkg::mem_none) ? op_raw : mips_id_pkg::alu_none;

endmodule

`default_nettype wire

// File: hdl/mips_id_pkg.sv
`default_nettype none

package mips_id_pkg;

    // ISA widths
    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;

    // return address register for jal, bgezal and bltzal
    localparam logic [reg_addr_w-1:0] link_reg = 5'd31;

    // primary opcode field, inst[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00, op_regimm = 6'h01, op_j     = 6'h02, op_jal   = 6'h03,
        op_beq     = 6'h04, op_bne    = 6'h05, op_blez  = 6'h06, op_bgtz  = 6'h07,
        op_addi    = 6'h08, op_addiu  = 6'h09, op_slti  = 6'h0a, op_sltiu = 6'h0b,
        op_andi    = 6'h0c, op_ori    = 6'h0d, op_xori  = 6'h0e, op_lui   = 6'h0f,
        op_lb      = 6'h20, op_lh     = 6'h21, op_lw    = 6'h23, op_lbu   = 6'h24,
        op_lhu     = 6'h25, op_sb     = 6'h28, op_sh    = 6'h29, op_sw    = 6'h2b
    } opcode_e;

    // SPECIAL function field, inst[5:0]
    typedef enum logic [5:0] {
        fn_sll  = 6'h00, fn_srl  = 6'h02, fn_sra  = 6'h03, fn_sllv = 6'h04,
        fn_srlv = 6'h06, fn_srav = 6'h07, fn_jr   = 6'h08, fn_jalr = 6'h09,
        fn_add  = 6'h20, fn_addu = 6'h21, fn_sub  = 6'h22, fn_subu = 6'h23,
        fn_and  = 6'h24, fn_or   = 6'h25, fn_xor  = 6'h26, fn_nor  = 6'h27,
        fn_slt  = 6'h2a, fn_sltu = 6'h2b
    } funct_e;

    // EX stage ALU operation
    typedef enum logic [3:0] {
        alu_none, alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_nor,
        alu_or, alu_xor, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {
        src1_rs, src1_pc, src1_sa
    } alu_src1_e;

    typedef enum logic [2:0] {
        src2_none, src2_rt, src2_imm_sign, src2_imm_zero, src2_eight
    } alu_src2_e;

    // byte enables and extension are derived from this in EX
    typedef enum logic [3:0] {
        mem_none, mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw, mem_sb, mem_sh, mem_sw
    } mem_op_e;

    typedef enum logic [3:0] {
        br_none, br_beq, br_bne, br_bgez, br_bgtz, br_blez, br_bltz,
        br_bgezal, br_bltzal, br_j, br_jal, br_jr, br_jalr
    } br_kind_e;

endpackage

`default_nettype wire

// File: hdl/mips_id_stage.sv
`default_nettype none

module mips_id_stage (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire  [mips_id_pkg::word_w-1:0]       if_pc,
    input  wire                                  if_ce,
    input  wire  [mips_id_pkg::word_w-1:0]       inst_rdata,
    input  wire                                  id_stall,
    input  wire                                  ex_stall,
    input  wire                                  wb_we,
    input  wire  [mips_id_pkg::reg_addr_w-1:0]   wb_waddr,
    input  wire  [mips_id_pkg::word_w-1:0]       wb_wdata,
    input  wire                                  ex_we,
    input  wire  [mips_id_pkg::reg_addr_w-1:0]   ex_waddr,
    input  wire  [mips_id_pkg::word_w-1:0]       ex_wdata,
    input  wire                                  ex_is_load,
    input  wire                                  mem_we,
    input  wire  [mips_id_pkg::reg_addr_w-1:0]   mem_waddr,
    input  wire  [mips_id_pkg::word_w-1:0]       mem_wdata,
    output logic [mips_id_pkg::word_w-1:0]       id_pc,
    output logic [mips_id_pkg::word_w-1:0]       id_inst,
    output mips_id_pkg::alu_op_e                 alu_op,
    output mips_id_pkg::alu_src1_e               alu_src1,
    output mips_id_pkg::alu_src2_e               alu_src2,
    output mips_id_pkg::mem_op_e                 mem_op,
    output logic                                 rf_we,
    output logic [mips_id_pkg::reg_addr_w-1:0]   rf_waddr,
    output logic [mips_id_pkg::word_w-1:0]       rs_value,
    output logic [mips_id_pkg::word_w-1:0]       rt_value,
    output logic                                 br_taken,
    output logic [mips_id_pkg::word_w-1:0]       br_target,
    output logic                                 stall_req
);

    mips_id_pkg::br_kind_e             br_kind;
    logic [mips_id_pkg::word_w-1:0]    rf_rdata1;
    logic [mips_id_pkg::word_w-1:0]    rf_rdata2;

    if_id_latch u_if_id_latch (
        .clk(clk), .rst(rst), .if_pc(if_pc), .if_ce(if_ce), .inst_rdata(inst_rdata),
        .id_stall(id_stall), .ex_stall(ex_stall), .id_pc(id_pc), .id_inst(id_inst)
    );

    inst_decoder u_inst_decoder (
        .id_inst(id_inst), .alu_op(alu_op), .alu_src1(alu_src1), .alu_src2(alu_src2),
        .mem_op(mem_op), .rf_we(rf_we), .rf_waddr(rf_waddr), .br_kind(br_kind)
    );

    // register file is written by the WB stage
    reg_file u_reg_file (
        .clk(clk), .raddr1(id_inst[25:21]), .raddr2(id_inst[20:16]),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2),
        .we(wb_we), .waddr(wb_waddr), .wdata(wb_wdata)
    );

    operand_forward u_operand_forward (
        .rs_addr(id_inst[25:21]), .rt_addr(id_inst[20:16]),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .ex_we(ex_we), .ex_waddr(ex_waddr), .ex_wdata(ex_wdata), .ex_is_load(ex_is_load),
        .mem_we(mem_we), .mem_waddr(mem_waddr), .mem_wdata(mem_wdata),
        .wb_we(wb_we), .wb_waddr(wb_waddr), .wb_wdata(wb_wdata),
        .rs_value(rs_value), .rt_value(rt_value), .stall_req(stall_req)
    );

    branch_unit u_branch_unit (
        .id_pc(id_pc), .id_inst(id_inst), .br_kind(br_kind),
        .rs_value(rs_value), .rt_value(rt_value),
        .br_taken(br_taken), .br_target(br_target)
    );

endmodule

`default_nettype wire

// File: hdl/operand_forward.sv
`default_nettype none

module operand_forward (
    input  wire  [mips_id_pkg::reg_addr_w-1:0]   rs_addr,
    input  wire  [mips_id_pkg::reg_addr_w-1:0]   rt_addr,
    input  wire  [mips_id_pkg::word_w-1:0]       rf_rdata1,
    input  wire  [mips_id_pkg::word_w-1:0]       rf_rdata2,
    input  wire                                  ex_we,
    input  wire  [mips_id_pkg::reg_addr_w-1:0]   ex_waddr,
    input  wire  [mips_id_pkg::word_w-1:0]       ex_wdata,
    input  wire                                  ex_is_load,
    input  wire                                  mem_we,
    input  wire  [mips_id_pkg::reg_addr_w-1:0]   mem_waddr,
    input  wire  [mips_id_pkg::word_w-1:0]       mem_wdata,
    input  wire                                  wb_we,
    input  wire  [mips_id_pkg::reg_addr_w-1:0]   wb_waddr,
    input  wire  [mips_id_pkg::word_w-1:0]       wb_wdata,
    output logic [mips_id_pkg::word_w-1:0]       rs_value,
    output logic [mips_id_pkg::word_w-1:0]       rt_value,
    output logic                                 stall_req
);

    // youngest producer wins
    function automatic logic [mips_id_pkg::word_w-1:0] pick(
        input logic [mips_id_pkg::reg_addr_w-1:0] addr,
        input logic [mips_id_pkg::word_w-1:0]     rf_val
    );
        if (addr == '0) return '0;
        if (ex_we && ex_waddr == addr) return ex_wdata;
        if (mem_we && mem_waddr == addr) return mem_wdata;
        if (wb_we && wb_waddr == addr) return wb_wdata;
        return rf_val;
    endfunction

    always_comb begin
        rs_value = pick(rs_addr, rf_rdata1);
        rt_value = pick(rt_addr, rf_rdata2);
    end

    // load data is not ready until MEM, so hold ID one cycle
    assign stall_req = ex_is_load && ex_we && (ex_waddr != '0)
                    && (ex_waddr == rs_addr || ex_waddr == rt_addr);

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`default_nettype none

module reg_file (
    input  wire                                  clk,
    input  wire  [mips_id_pkg::reg_addr_w-1:0]   raddr1,
    input  wire  [mips_id_pkg::reg_addr_w-1:0]   raddr2,
    output logic [mips_id_pkg::word_w-1:0]       rdata1,
    output logic [mips_id_pkg::word_w-1:0]       rdata2,
    input  wire                                  we,
    input  wire  [mips_id_pkg::reg_addr_w-1:0]   waddr,
    input  wire  [mips_id_pkg::word_w-1:0]       wdata
);

    logic [mips_id_pkg::word_w-1:0] regs [2**mips_id_pkg::reg_addr_w];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is never written, so force it on read
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: mips_id.f
hdl/mips_id_pkg.sv
hdl/if_id_latch.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/operand_forward.sv
hdl/branch_unit.sv
hdl/mips_id_stage.sv
testbench/mips_id_asserts.sv
testbench/mips_id_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the ID stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f mips_id.f \
    --top-module mips_id_tb \
    -o sim_mips_id
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_mips_id 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Everything OK" <<< "$output"; then
    exit 0
fi
exit 1

// File: testbench/mips_id_asserts.sv
`default_nettype none

module mips_id_asserts (
    input wire                                 clk,
    input wire                                 rst,
    input wire                                 id_stall,
    input wire                                 ex_stall,
    input wire [mips_id_pkg::word_w-1:0]       id_inst,
    input wire                                 rf_we,
    input wire [mips_id_pkg::reg_addr_w-1:0]   rf_waddr,
    input wire                                 br_taken
);

    // a full stall holds the instruction while the memory output moves on
    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        (id_stall && ex_stall) |=> $stable(id_inst))
        else $error("id_inst changed during a full stall");

    // bubble writes nothing and never redirects fetch
    a_bubble_quiet: assert property (@(posedge clk) disable iff (rst)
        (id_inst == '0) |-> (!rf_we && !br_taken))
        else $error("zero instruction writes or branches");

    // jal, bltzal and bgezal link into r31
    a_link_reg: assert property (@(posedge clk) disable iff (rst)
        ((id_inst[31:26] == mips_id_pkg::op_jal)
         || (id_inst[31:26] == mips_id_pkg::op_regimm && id_inst[20:17] == 4'b1000))
        |-> (rf_waddr == mips_id_pkg::link_reg))
        else $error("link destination is not r31");

    a_reset_no_branch: assert property (@(posedge clk) rst |=> !br_taken)
        else $error("br_taken high after reset");

endmodule

bind mips_id_stage mips_id_asserts u_asserts (.*);

`default_nettype wire

// File: testbench/mips_id_input.txt
// type pc inst | wb we/addr/data ex we/addr/data mem we/addr/data ex_is_load id_stall ex_stall
// expected: alu_op mem_op rf_we rf_waddr rs_value rt_value br_taken br_target stall_req
0 1000 0 1 5 11111111 1 0 dead0000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 1010 0 1 6 22222222 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 1020 0 1 7 fffffff0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 1030 00A61820 0 0 0 0 0 0 0 0 0 0 0 0 1 0 1 3 11111111 22222222 0 0 0
0 1040 00A61820 1 5 cccc0003 1 5 aaaa0001 1 5 bbbb0002 0 0 0 1 0 1 3 aaaa0001 22222222 0 0 0
0 1050 00A61820 1 5 cccc0003 0 0 0 1 5 bbbb0002 0 0 0 1 0 1 3 bbbb0002 22222222 0 0 0
0 1060 00A61820 1 5 cccc0003 0 0 0 0 0 0 0 0 0 1 0 1 3 cccc0003 22222222 0 0 0
0 1070 00052025 0 0 0 0 0 0 0 0 0 0 0 0 7 0 1 4 0 cccc0003 0 0 0
0 1080 8CC50004 0 0 0 0 0 0 0 0 0 0 0 0 1 5 1 5 22222222 cccc0003 0 0 0
0 1090 ACE60008 0 0 0 0 0 0 0 0 0 0 0 0 1 8 0 0 fffffff0 22222222 0 0 0
0 10a0 34A61234 0 0 0 0 0 0 0 0 0 0 0 0 7 0 1 6 cccc0003 22222222 0 0 0
1 10b0 10A50004 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 cccc0003 cccc0003 1 10c4 0
1 10c0 14A6FFFE 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 cccc0003 22222222 1 10bc 0
0 10d0 1CE00005 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 fffffff0 0 0 0 0
1 10e0 18E00003 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 fffffff0 0 1 10f0 0
0 10f0 04C00010 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 22222222 0 0 0 0
1 1100 04C10010 0 0 0 0 0 0 1 1 0 0 0 0 0 0 0 0 22222222 0 1 1144 0
1 1110 0C000100 0 0 0 0 0 0 0 0 0 0 0 0 1 0 1 1f 0 0 1 400 0
1 1120 08002000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 8000 0
1 1130 00C00008 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 22222222 0 1 22222222 0
0 1140 00A61820 0 0 0 1 6 33 0 0 0 1 0 0 1 0 1 3 cccc0003 33 0 0 1
0 1150 00A61820 0 0 0 0 0 0 0 0 0 0 1 1 1 0 1 3 cccc0003 22222222 0 0 0
0 1160 8CC50004 0 0 0 0 0 0 0 0 0 0 1 0 1 5 1 5 22222222 cccc0003 0 0 0

// File: testbench/mips_id_tb.sv
`default_nettype none

module mips_id_tb;

    localparam int fields     = 24;
    localparam int max_vec    = 64;
    localparam int wait_limit = 10;

    logic clk, rst;
    logic [31:0] if_pc, inst_rdata, wb_wdata, ex_wdata, mem_wdata;
    logic if_ce, id_stall, ex_stall, wb_we, ex_we, ex_is_load, mem_we;
    logic [4:0] wb_waddr, ex_waddr, mem_waddr;
    logic [31:0] id_pc, id_inst, rs_value, rt_value, br_target;
    logic rf_we, br_taken, stall_req;
    logic [4:0] rf_waddr;
    mips_id_pkg::alu_op_e   alu_op;
    mips_id_pkg::alu_src1_e alu_src1;
    mips_id_pkg::alu_src2_e alu_src2;
    mips_id_pkg::mem_op_e   mem_op;

    logic [31:0] vec [fields*max_vec];
    logic [31:0] imem [logic [31:0]];
    int idx;

    mips_id_stage UUT (.*);

    always #10 clk = ~clk;

    // synchronous instruction memory, unmapped words follow the address
    always @(posedge clk) begin
        if (imem.exists(if_pc))
            inst_rdata <= imem[if_pc];
        else
            inst_rdata <= if_pc ^ 32'h5a5a_c3c3;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp)
            fail_now($sformatf("ERROR at %0t: %s is %h, expected %h", $time, name, act, exp));
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp)
            fail_now($sformatf("ERROR at %0t: %s is %b, expected %b", $time, name, act, exp));
    endtask

    task automatic check_addr(input string name, input logic [4:0] act, input logic [4:0] exp);
        if (act !== exp)
            fail_now($sformatf("ERROR at %0t: %s is %0d, expected %0d", $time, name, act, exp));
    endtask

    task automatic check_alu_op(input string name, input mips_id_pkg::alu_op_e act,
                                input mips_id_pkg::alu_op_e exp);
        if (act !== exp)
            fail_now($sformatf("ERROR at %0t: %s is %s, expected %s",
                               $time, name, act.name(), exp.name()));
    endtask

    task automatic check_mem_op(input string name, input mips_id_pkg::mem_op_e act,
                                input mips_id_pkg::mem_op_e exp);
        if (act !== exp)
            fail_now($sformatf("ERROR at %0t: %s is %s, expected %s",
                               $time, name, act.name(), exp.name()));
    endtask

    task automatic check_src1(input string name, input mips_id_pkg::alu_src1_e act,
                              input mips_id_pkg::alu_src1_e exp);
        if (act !== exp)
            fail_now($sformatf("ERROR at %0t: %s is %s, expected %s",
                               $time, name, act.name(), exp.name()));
    endtask

    task automatic check_src2(input string name, input mips_id_pkg::alu_src2_e act,
                              input mips_id_pkg::alu_src2_e exp);
        if (act !== exp)
            fail_now($sformatf("ERROR at %0t: %s is %s, expected %s",
                               $time, name, act.name(), exp.name()));
    endtask

    // ALU operand sources by instruction class
    task automatic check_sources(input logic [31:0] inst);
        logic link;
        mips_id_pkg::alu_src1_e exp1;
        mips_id_pkg::alu_src2_e exp2;
        // jal, jalr and the linking REGIMM branches compute pc + 8
        link = (inst[31:26] == mips_id_pkg::op_jal)
            || (inst[31:26] == mips_id_pkg::op_special && inst[5:0] == mips_id_pkg::fn_jalr)
            || (inst[31:26] == mips_id_pkg::op_regimm && inst[20]);
        exp1 = mips_id_pkg::src1_rs;
        exp2 = mips_id_pkg::src2_imm_sign;
        if (inst[31:26] == mips_id_pkg::op_special) begin
            exp2 = mips_id_pkg::src2_rt;
            // constant shifts use the sa field
            if (inst[5:0] inside {mips_id_pkg::fn_sll, mips_id_pkg::fn_srl, mips_id_pkg::fn_sra})
                exp1 = mips_id_pkg::src1_sa;
        end else if (inst[31:26] inside {mips_id_pkg::op_andi, mips_id_pkg::op_ori,
                                         mips_id_pkg::op_xori}) begin
            exp2 = mips_id_pkg::src2_imm_zero;
        end
        if (link) begin
            exp1 = mips_id_pkg::src1_pc;
            exp2 = mips_id_pkg::src2_eight;
        end
        check_src1("alu_src1", alu_src1, exp1);
        check_src2("alu_src2", alu_src2, exp2);
    endtask

    // poll on falling edges until ID shows the given pc and word
    task automatic wait_for_inst(input logic [31:0] pc, input logic [31:0] inst);
        int n;
        n = 0;
        @(negedge clk);
        while (!(id_pc === pc && id_inst === inst)) begin
            n++;
            if (n > wait_limit)
                fail_now($sformatf("timeout waiting for pc %h to reach the ID stage", pc));
            @(negedge clk);
        end
    endtask

    task automatic check_outputs(input int base);
        check_alu_op("alu_op", alu_op, mips_id_pkg::alu_op_e'(vec[base+15][3:0]));
        check_mem_op("mem_op", mem_op, mips_id_pkg::mem_op_e'(vec[base+16][3:0]));
        check_bit("rf_we", rf_we, vec[base+17][0]);
        check_addr("rf_waddr", rf_waddr, vec[base+18][4:0]);
        check_word("rs_value", rs_value, vec[base+19]);
        check_word("rt_value", rt_value, vec[base+20]);
        check_bit("br_taken", br_taken, vec[base+21][0]);
        // target only matters for branch vectors
        if (vec[base][0])
            check_word("br_target", br_target, vec[base+22]);
        check_bit("stall_req", stall_req, vec[base+23][0]);
        // sources only mean something while the ALU is in use
        if (mips_id_pkg::alu_op_e'(vec[base+15][3:0]) != mips_id_pkg::alu_none)
            check_sources(vec[base+2]);
    endtask

    task automatic run_vector(input int base);
        logic [31:0] pc;
        logic [31:0] inst;
        pc = vec[base+1];
        inst = vec[base+2];
        imem[pc] = inst;
        @(posedge clk);
        if_pc      <= pc;
        if_ce      <= 1'b1;
        wb_we      <= vec[base+3][0];
        wb_waddr   <= vec[base+4][4:0];
        wb_wdata   <= vec[base+5];
        ex_we      <= vec[base+6][0];
        ex_waddr   <= vec[base+7][4:0];
        ex_wdata   <= vec[base+8];
        mem_we     <= vec[base+9][0];
        mem_waddr  <= vec[base+10][4:0];
        mem_wdata  <= vec[base+11];
        ex_is_load <= vec[base+12][0];
        id_stall   <= 1'b0;
        ex_stall   <= 1'b0;
        wait_for_inst(pc, inst);
        check_outputs(base);
        if (vec[base+13][0] && vec[base+14][0]) begin
            // full stall, memory output moves on to another address
            @(posedge clk);
            id_stall <= 1'b1;
            ex_stall <= 1'b1;
            if_pc    <= pc ^ 32'h8000_0000;
            repeat (3) begin
                @(negedge clk);
                check_word("id_inst", id_inst, inst);
                check_outputs(base);
            end
        end else if (vec[base+13][0]) begin
            @(posedge clk);
            id_stall <= 1'b1;
            ex_stall <= 1'b0;
            wait_for_inst(pc, 32'h0);
            check_bit("rf_we", rf_we, 1'b0);
            check_mem_op("mem_op", mem_op, mips_id_pkg::mem_none);
            check_alu_op("alu_op", alu_op, mips_id_pkg::alu_none);
            check_bit("br_taken", br_taken, 1'b0);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        if_pc = '0;
        if_ce = 1'b0;
        inst_rdata = '0;
        {id_stall, ex_stall, wb_we, ex_we, ex_is_load, mem_we} = '0;
        {wb_waddr, ex_waddr, mem_waddr} = '0;
        {wb_wdata, ex_wdata, mem_wdata} = '0;
        for (int i = 0; i < fields*max_vec; i++)
            vec[i] = 32'hffff_ffff;
        $readmemh("testbench/mips_id_input.txt", vec);
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("rf_we", rf_we, 1'b0);
        check_bit("br_taken", br_taken, 1'b0);
        check_bit("stall_req", stall_req, 1'b0);
        check_mem_op("mem_op", mem_op, mips_id_pkg::mem_none);
        check_alu_op("alu_op", alu_op, mips_id_pkg::alu_none);
        idx = 0;
        while (idx < max_vec && vec[idx*fields] != 32'hffff_ffff) begin
            run_vector(idx*fields);
            idx++;
        end
        if (idx == 0) begin
            fail_now("no vectors were read from the data file");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

`default_nettype wire
